//--- hw/crossing_defines.svh
`ifndef CROSSING_DEFINES_SVH
`define CROSSING_DEFINES_SVH

// ----------------------------------------
// playfield
// ----------------------------------------
`define GRID_COLS 8
`define GRID_ROWS 6
`define START_COL 3
`define START_ROW 5

// one bit per flat cell index, row * 8 + col
`define BRICK_MAP 48'h0000_0000_006d // row 0, cols 0 2 3 5 6
`define GOAL_MAP  48'h0000_0000_0092 // row 0, cols 1 4 7

// ----------------------------------------
// car lane
// ----------------------------------------
`define CAR_COUNT 3
`define CAR_ROW   4
`define CAR_START_COLS {3'd6, 3'd3, 3'd0} // car 0 in the low bits

// strobe periods in clk_debounce cycles
`define CAR_TICK_DIV   16
`define SCAN_TICK_DIV  4
`define CHASE_TICK_DIV 8

`endif

//--- hw/game_pkg.sv
`default_nettype none
`include "crossing_defines.svh"

package game_pkg;

    // row and col view of a grid cell
    typedef struct packed {
        logic [2:0] row;
        logic [2:0] col;
    } cell_rc_t;

    // same six bits read as a flat index into the hazard maps
    typedef union packed {
        cell_rc_t   rc;
        logic [5:0] idx;
    } cell_u;

    typedef enum logic [1:0] {
        MOVE = 2'd0,
        DIE  = 2'd1,
        WIN  = 2'd2
    } game_state_e;

    // one column per car, all cars share `CAR_ROW
    typedef logic [`CAR_COUNT-1:0][2:0] car_cols_t;

endpackage

`default_nettype wire

//--- hw/display_pkg.sv
`default_nettype none

package display_pkg;

    typedef logic [3:0]  bcd_digit_t;
    typedef logic [7:0]  seg_t;      // a b c d e f g dp, active high
    typedef logic [3:0]  digit_en_t; // one-hot, bit 0 is the ones digit
    typedef logic [15:0] led_t;

    localparam seg_t SEG_GLYPH [16] = '{
        8'b1111_1100, // 0
        8'b0110_0000, // 1
        8'b1101_1010, // 2
        8'b1111_0010, // 3
        8'b0110_0110, // 4
        8'b1011_0110, // 5
        8'b1011_1110, // 6
        8'b1110_0100, // 7
        8'b1111_1110, // 8
        8'b1111_0110, // 9
        8'b0000_0000, // non-decimal codes stay dark
        8'b0000_0000,
        8'b0000_0000,
        8'b0000_0000,
        8'b0000_0000,
        8'b0000_0000
    };

    localparam seg_t WIN_GLYPH = 8'b1111_0110; // shown as "9"

endpackage

`default_nettype wire

//--- hw/board_if.sv
`default_nettype none

interface board_if import game_pkg::*, display_pkg::*; ();

    cell_u       player_cell;
    car_cols_t   car_cols;
    game_state_e state;
    bcd_digit_t  step_ones;
    bcd_digit_t  step_tens;

    modport player (
        output player_cell, step_ones, step_tens,
        input  state
    );

    modport lane (
        output car_cols,
        input  state
    );

    modport rules (
        input  player_cell, car_cols,
        output state
    );

    modport panel (
        input state, step_ones, step_tens
    );

endinterface

`default_nettype wire

//--- hw/tick_gen.sv
`default_nettype none
`include "crossing_defines.svh"

module tick_gen (
    input  wire clk_debounce,
    input  wire reset,
    output wire car_tick,
    output wire scan_tick,
    output wire chase_tick
);

    localparam int CNT_W = 8;

    logic [2:0] tick;

    // one down-counter per strobe, all restart at reset release
    for (genvar i = 0; i < 3; i++) begin : g_div
        localparam int DIV = (i == 0) ? `CAR_TICK_DIV :
                             (i == 1) ? `SCAN_TICK_DIV : `CHASE_TICK_DIV;

        logic [CNT_W-1:0] cnt;

        always_ff @(posedge clk_debounce or negedge reset) begin
            if (!reset) begin
                cnt <= CNT_W'(DIV - 1);
            end else if (cnt == '0) begin
                cnt <= CNT_W'(DIV - 1); // reload
            end else begin
                cnt <= cnt - 1'b1;
            end
        end

        assign tick[i] = (cnt == '0); // edge DIV, 2*DIV, ... acts on it
    end

    assign car_tick   = tick[0];
    assign scan_tick  = tick[1];
    assign chase_tick = tick[2];

endmodule

`default_nettype wire

//--- hw/player_ctrl.sv
`default_nettype none
`include "crossing_defines.svh"

module player_ctrl import game_pkg::*; (
    input  wire     clk_debounce,
    input  wire     reset,
    input  wire     btn_up,
    input  wire     btn_left,
    input  wire     btn_right,
    board_if.player board
);

    localparam int UP    = 0;
    localparam int LEFT  = 1;
    localparam int RIGHT = 2;

    logic [2:0] sync_q1;
    logic [2:0] sync_q2;
    logic [2:0] sync_q3;
    logic [2:0] btn_rise;
    cell_u      next_cell;
    logic       moved;

    // ----------------------------------------
    // button sync and rising edge
    // ----------------------------------------
    always_ff @(posedge clk_debounce or negedge reset) begin
        if (!reset) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
            sync_q3 <= '0;
        end else begin
            sync_q1 <= {btn_right, btn_left, btn_up};
            sync_q2 <= sync_q1;
            sync_q3 <= sync_q2;
        end
    end

    assign btn_rise = sync_q2 & ~sync_q3; // held button fires once

    // left over right over up, a blocked move is dropped
    always_comb begin
        next_cell = board.player_cell;
        moved     = 1'b0;
        if (btn_rise[LEFT]) begin
            if (board.player_cell.rc.col != 3'd0) begin
                next_cell.rc.col = board.player_cell.rc.col - 3'd1;
                moved            = 1'b1;
            end
        end else if (btn_rise[RIGHT]) begin
            if (board.player_cell.rc.col != 3'(`GRID_COLS - 1)) begin
                next_cell.rc.col = board.player_cell.rc.col + 3'd1;
                moved            = 1'b1;
            end
        end else if (btn_rise[UP]) begin
            if (board.player_cell.rc.row != 3'd0) begin
                next_cell.rc.row = board.player_cell.rc.row - 3'd1;
                moved            = 1'b1;
            end
        end
    end

    // ----------------------------------------
    // position and decimal step count
    // ----------------------------------------
    always_ff @(posedge clk_debounce or negedge reset) begin
        if (!reset) begin
            board.player_cell.rc.row <= 3'(`START_ROW);
            board.player_cell.rc.col <= 3'(`START_COL);
            board.step_ones          <= 4'd0;
            board.step_tens          <= 4'd0;
        end else if (board.state == MOVE && moved) begin
            board.player_cell <= next_cell;
            if (board.step_ones == 4'd9) begin
                board.step_ones <= 4'd0;
                board.step_tens <= (board.step_tens == 4'd9) ? 4'd0 : board.step_tens + 4'd1;
            end else begin
                board.step_ones <= board.step_ones + 4'd1;
            end
        end
    end

    // col spans all 8 codes, only the row can leave the grid
    player_in_grid_a: assert property (@(posedge clk_debounce) disable iff (!reset)
        int'(board.player_cell.rc.row) < `GRID_ROWS);

endmodule

`default_nettype wire

//--- hw/car_lane.sv
`default_nettype none
`include "crossing_defines.svh"

module car_lane import game_pkg::*; (
    input  wire   clk_debounce,
    input  wire   reset,
    input  wire   car_tick,
    board_if.lane board
);

    car_cols_t next_cols;

    // every car one column on, wrapping at the right edge
    always_comb begin
        for (int i = 0; i < `CAR_COUNT; i++) begin
            if (board.car_cols[i] == 3'(`GRID_COLS - 1)) begin
                next_cols[i] = 3'd0;
            end else begin
                next_cols[i] = board.car_cols[i] + 3'd1;
            end
        end
    end

    always_ff @(posedge clk_debounce or negedge reset) begin
        if (!reset) begin
            board.car_cols <= `CAR_START_COLS;
        end else if (car_tick && board.state == MOVE) begin
            board.car_cols <= next_cols; // lane freezes once the game ends
        end
    end

endmodule

`default_nettype wire

//--- hw/game_rules.sv
`default_nettype none
`include "crossing_defines.svh"

module game_rules import game_pkg::*; (
    input  wire    clk_debounce,
    input  wire    reset,
    board_if.rules board
);

    localparam logic [`GRID_COLS*`GRID_ROWS-1:0] BRICK_CELLS = `BRICK_MAP;
    localparam logic [`GRID_COLS*`GRID_ROWS-1:0] GOAL_CELLS  = `GOAL_MAP;

    logic        car_hit;
    logic        on_brick;
    logic        on_goal;
    game_state_e state_nxt;

    // ----------------------------------------
    // hazard lookup
    // ----------------------------------------
    always_comb begin
        car_hit = 1'b0;
        if (board.player_cell.rc.row == 3'(`CAR_ROW)) begin
            for (int i = 0; i < `CAR_COUNT; i++) begin
                if (board.car_cols[i] == board.player_cell.rc.col) begin
                    car_hit = 1'b1;
                end
            end
        end
    end

    assign on_brick = BRICK_CELLS[board.player_cell.idx]; // flat view of the cell
    assign on_goal  = GOAL_CELLS[board.player_cell.idx];

    // ----------------------------------------
    // controller
    // ----------------------------------------
    always_comb begin
        state_nxt = board.state;
        if (board.state == MOVE) begin
            if (car_hit || on_brick) begin
                state_nxt = DIE;
            end else if (on_goal) begin
                state_nxt = WIN;
            end
        end
    end

    always_ff @(posedge clk_debounce or negedge reset) begin
        if (!reset) begin
            board.state <= MOVE;
        end else begin
            board.state <= state_nxt;
        end
    end

    end_state_final_a: assert property (@(posedge clk_debounce) disable iff (!reset)
        board.state != MOVE |=> $stable(board.state));

    // player and lane modules must both honour the freeze
    board_frozen_a: assert property (@(posedge clk_debounce) disable iff (!reset)
        board.state != MOVE |=> $stable(board.player_cell) && $stable(board.car_cols));

endmodule

`default_nettype wire

//--- hw/panel_driver.sv
`default_nettype none

module panel_driver import game_pkg::*, display_pkg::*; (
    input  wire         clk_debounce,
    input  wire         reset,
    input  wire         scan_tick,
    input  wire         chase_tick,
    board_if.panel      board,
    output seg_t        segment,
    output digit_en_t   digit_enable,
    output led_t        led
);

    logic [2:0] chase_cnt;
    led_t       chase_pattern;

    // ----------------------------------------
    // digit scan
    // ----------------------------------------
    always_ff @(posedge clk_debounce or negedge reset) begin
        if (!reset) begin
            digit_enable <= 4'b0001;
        end else if (scan_tick) begin
            if (board.state == WIN) begin
                digit_enable <= {digit_enable[2:0], digit_enable[3]}; // all four digits
            end else if (digit_enable == 4'b0001) begin
                digit_enable <= 4'b0010;
            end else begin
                digit_enable <= 4'b0001;
            end
        end
    end

    always_comb begin
        case (digit_enable)
            4'b0001: segment = SEG_GLYPH[board.step_ones];
            4'b0010: segment = SEG_GLYPH[board.step_tens];
            default: segment = WIN_GLYPH; // upper pair, only reached in WIN
        endcase
    end

    // ----------------------------------------
    // LED chase while dead
    // ----------------------------------------
    always_ff @(posedge clk_debounce or negedge reset) begin
        if (!reset) begin
            chase_cnt <= 3'd0;
        end else if (board.state != DIE) begin
            chase_cnt <= 3'd0;
        end else if (chase_tick) begin
            chase_cnt <= chase_cnt + 3'd1;
        end
    end

    // mirrored pair, middle outward
    assign chase_pattern = (led_t'(16'h0080) >> chase_cnt) | (led_t'(16'h0100) << chase_cnt);
    assign led = (board.state == DIE) ? chase_pattern : '0;

    digit_scan_a: assert property (@(posedge clk_debounce) disable iff (!reset)
        $onehot(digit_enable) && (board.state == WIN || digit_enable[3:2] == 2'b00));

endmodule

`default_nettype wire

//--- hw/crossing_top.sv
`default_nettype none

module crossing_top import display_pkg::*; (
    input  wire       clk_debounce,
    input  wire       reset,
    input  wire       btn_up,
    input  wire       btn_left,
    input  wire       btn_right,
    output seg_t      segment,
    output digit_en_t digit_enable,
    output led_t      led
);

    wire car_tick;
    wire scan_tick;
    wire chase_tick;

    board_if board_inst ();

    tick_gen tick_gen_inst (
        .clk_debounce (clk_debounce),
        .reset        (reset),
        .car_tick     (car_tick),
        .scan_tick    (scan_tick),
        .chase_tick   (chase_tick)
    );

    player_ctrl player_ctrl_inst (
        .clk_debounce (clk_debounce),
        .reset        (reset),
        .btn_up       (btn_up),
        .btn_left     (btn_left),
        .btn_right    (btn_right),
        .board        (board_inst.player)
    );

    car_lane car_lane_inst (
        .clk_debounce (clk_debounce),
        .reset        (reset),
        .car_tick     (car_tick),
        .board        (board_inst.lane)
    );

    game_rules game_rules_inst (
        .clk_debounce (clk_debounce),
        .reset        (reset),
        .board        (board_inst.rules)
    );

    panel_driver panel_driver_inst (
        .clk_debounce (clk_debounce),
        .reset        (reset),
        .scan_tick    (scan_tick),
        .chase_tick   (chase_tick),
        .board        (board_inst.panel),
        .segment      (segment),
        .digit_enable (digit_enable),
        .led          (led)
    );

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`default_nettype none

module tb_clock (
    input  wire  reset_req,
    output logic clk_debounce,
    output logic reset
);

    logic rst_q       = 1'b0;
    int   hold_cycles = 5;

    initial begin
        clk_debounce = 1'b0;
        forever begin
            #20 clk_debounce = ~clk_debounce;
        end
    end

    // reset low for 5 rising edges, at start and after each request
    always @(posedge clk_debounce) begin
        if (reset_req) begin
            rst_q       <= 1'b0;
            hold_cycles <= 5;
        end else if (hold_cycles != 0) begin
            hold_cycles <= hold_cycles - 1;
            if (hold_cycles == 1) begin
                rst_q <= 1'b1;
            end
        end
    end

    assign reset = rst_q;

endmodule

`default_nettype wire

//--- test/crossing_tb.sv
`default_nettype none
`include "crossing_defines.svh"

module crossing_tb import game_pkg::*, display_pkg::*; ();

    localparam logic [2:0] UP_BTN    = 3'b001; // {right, left, up}
    localparam logic [2:0] LEFT_BTN  = 3'b010;
    localparam logic [2:0] RIGHT_BTN = 3'b100;
    localparam int CAR_START [`CAR_COUNT] = '{0, 3, 6};
    localparam int GAP_SEARCH = 160;

    // cycle budget per test
    localparam int RESET_TEST_CYCLES = 60;
    localparam int MOVES_TEST_CYCLES = 120;
    localparam int ROLL_TEST_CYCLES  = 100;
    localparam int BRICK_TEST_CYCLES = 280;
    localparam int CAR_TEST_CYCLES   = 200;
    localparam int WIN_TEST_CYCLES   = 270;
    localparam int TIMEOUT_CYCLES    = RESET_TEST_CYCLES + MOVES_TEST_CYCLES + ROLL_TEST_CYCLES
                                     + BRICK_TEST_CYCLES + CAR_TEST_CYCLES + WIN_TEST_CYCLES + 200;

    wire       clk_debounce;
    wire       reset;
    logic      reset_req;
    logic      btn_up;
    logic      btn_left;
    logic      btn_right;
    seg_t      segment;
    digit_en_t digit_enable;
    led_t      led;

    // reference model
    int          m_cyc;  // edges since reset release
    logic [2:0]  m_s1;
    logic [2:0]  m_s2;
    logic [2:0]  m_s3;
    int          m_row;
    int          m_col;
    int          m_steps;
    int          m_chase;
    int          m_car [`CAR_COUNT];
    game_state_e m_state;
    digit_en_t   m_digit;
    logic        rst_prev;
    logic [2:0]  btn_prev;
    int          cycle_cnt = 0;

    tb_clock clock_inst (
        .reset_req    (reset_req),
        .clk_debounce (clk_debounce),
        .reset        (reset)
    );

    crossing_top crossing_top_inst (
        .clk_debounce (clk_debounce),
        .reset        (reset),
        .btn_up       (btn_up),
        .btn_left     (btn_left),
        .btn_right    (btn_right),
        .segment      (segment),
        .digit_enable (digit_enable),
        .led          (led)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "testbench stopped");
    endtask

    always @(posedge clk_debounce) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            fail_run("timeout, the tests ran past their cycle budget");
        end
    end

    task automatic check_seg(input seg_t got_seg, input seg_t exp_seg,
                             input digit_en_t got_en, input digit_en_t exp_en);
        if (got_en !== exp_en) begin
            fail_run($sformatf("mismatch digit_enable: got %h expected %h", got_en, exp_en));
        end
        if (got_seg !== exp_seg) begin
            fail_run($sformatf("mismatch segment: got %h expected %h", got_seg, exp_seg));
        end
    endtask

    task automatic check_led(input led_t got, input led_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch led: got %h expected %h", got, exp));
        end
    endtask

    function automatic seg_t glyph(input int digit);
        case (digit)
            0: return 8'hfc;
            1: return 8'h60;
            2: return 8'hda;
            3: return 8'hf2;
            4: return 8'h66;
            5: return 8'hb6;
            6: return 8'hbe;
            7: return 8'he4; // 7 with the f tail
            8: return 8'hfe;
            9: return 8'hf6;
            default: return 8'h00;
        endcase
    endfunction

    // no car in col over cycles from .. from+span-1
    function automatic logic lane_clear(input int col, input int from, input int span);
        for (int c = from; c < from + span; c++) begin
            for (int i = 0; i < `CAR_COUNT; i++) begin
                if ((CAR_START[i] + c / `CAR_TICK_DIV) % `GRID_COLS == col) begin
                    return 1'b0;
                end
            end
        end
        return 1'b1;
    endfunction

    // ----------------------------------------
    // model update, one call per rising edge
    // ----------------------------------------
    task automatic model_reset();
        m_cyc   = 0;
        m_s1    = '0;
        m_s2    = '0;
        m_s3    = '0;
        m_row   = `START_ROW;
        m_col   = `START_COL;
        m_steps = 0;
        m_chase = 0;
        m_state = MOVE;
        m_digit = 4'b0001;
        for (int i = 0; i < `CAR_COUNT; i++) begin
            m_car[i] = CAR_START[i];
        end
    endtask

    task automatic model_edge();
        logic [2:0]  rise;
        logic        hit;
        game_state_e st;
        int          row;
        int          col;
        rise  = m_s2 & ~m_s3;
        m_s3  = m_s2;
        m_s2  = m_s1;
        m_s1  = btn_prev;
        m_cyc = m_cyc + 1;
        hit   = 1'b0;
        for (int i = 0; i < `CAR_COUNT; i++) begin
            if (m_row == `CAR_ROW && m_car[i] == m_col) hit = 1'b1;
        end
        st = m_state;
        if (m_state == MOVE) begin
            if (hit || (m_row == 0 && m_col inside {0, 2, 3, 5, 6})) begin
                st = DIE;
            end else if (m_row == 0 && m_col inside {1, 4, 7}) begin
                st = WIN;
            end
            row = m_row;
            col = m_col;
            if (rise[1]) begin
                if (col > 0) col = col - 1;
            end else if (rise[2]) begin
                if (col < `GRID_COLS - 1) col = col + 1;
            end else if (rise[0]) begin
                if (row > 0) row = row - 1;
            end
            if (row != m_row || col != m_col) m_steps = (m_steps + 1) % 100;
            m_row = row;
            m_col = col;
            if (m_cyc % `CAR_TICK_DIV == 0) begin
                for (int i = 0; i < `CAR_COUNT; i++) begin
                    m_car[i] = (m_car[i] + 1) % `GRID_COLS;
                end
            end
        end
        if (m_cyc % `SCAN_TICK_DIV == 0) begin
            if (m_state == WIN) begin
                m_digit = {m_digit[2:0], m_digit[3]};
            end else begin
                m_digit = (m_digit == 4'b0001) ? 4'b0010 : 4'b0001;
            end
        end
        if (m_state != DIE) begin
            m_chase = 0;
        end else if (m_cyc % `CHASE_TICK_DIV == 0) begin
            m_chase = (m_chase + 1) % 8;
        end
        m_state = st;
    endtask

    task automatic compare_outputs();
        seg_t exp_seg;
        led_t exp_led;
        case (m_digit)
            4'b0001: exp_seg = glyph(m_steps % 10);
            4'b0010: exp_seg = glyph(m_steps / 10);
            default: exp_seg = glyph(9); // win glyph
        endcase
        exp_led = '0;
        if (m_state == DIE) begin
            exp_led = (led_t'(1) << (7 - m_chase)) | (led_t'(1) << (8 + m_chase));
        end
        check_seg(segment, exp_seg, digit_enable, m_digit);
        check_led(led, exp_led);
    endtask

    // ----------------------------------------
    // stimulus helpers
    // ----------------------------------------
    task automatic step(input logic [2:0] btns, input logic req = 1'b0);
        @(posedge clk_debounce);
        btn_up    <= btns[0];
        btn_left  <= btns[1];
        btn_right <= btns[2];
        reset_req <= req;
        @(negedge clk_debounce);
        if (!reset || !rst_prev) begin
            model_reset();
        end else begin
            model_edge();
        end
        rst_prev = reset;
        btn_prev = {btn_right, btn_left, btn_up};
        compare_outputs();
    endtask

    task automatic reset_dut();
        step(3'b000, 1'b1);
        step(3'b000);
        for (int i = 0; !reset; i++) begin
            if (i == 10) fail_run("reset was never released");
            step(3'b000);
        end
    endtask

    task automatic press(input logic [2:0] btns);
        step(btns);
        repeat (3) step(3'b000); // move lands on the last of these
    endtask

    task automatic wait_digit(input digit_en_t en);
        for (int i = 0; digit_enable !== en; i++) begin
            if (i == 4 * `SCAN_TICK_DIV + 4) fail_run($sformatf("digit %h never enabled", en));
            step(3'b000);
        end
    endtask

    task automatic expect_count(input int value);
        wait_digit(4'b0001);
        check_seg(segment, glyph(value % 10), digit_enable, 4'b0001);
        wait_digit(4'b0010);
        check_seg(segment, glyph(value / 10), digit_enable, 4'b0010);
    endtask

    task automatic wait_lane(input int col, input int from_off, input int span,
                             input logic want_clear);
        for (int i = 0; lane_clear(col, m_cyc + from_off, span) != want_clear; i++) begin
            if (i == GAP_SEARCH) fail_run("car lane never reached the wanted occupancy");
            step(3'b000);
        end
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic test_after_reset();
        reset_dut();
        repeat (6 * `SCAN_TICK_DIV) step(3'b000);
        expect_count(0);
    endtask

    task automatic test_moves_and_limits();
        reset_dut();
        repeat (4) press(RIGHT_BTN);
        expect_count(4);
        press(RIGHT_BTN); // already at col 7
        expect_count(4);
        press(LEFT_BTN);
        expect_count(5);
    endtask

    task automatic test_rollover();
        reset_dut();
        repeat (6) begin
            press(LEFT_BTN);
            press(RIGHT_BTN);
        end
        expect_count(12);
    endtask

    task automatic test_brick_death();
        reset_dut();
        wait_lane(`START_COL, 1, 12, 1'b1);
        repeat (5) press(UP_BTN);
        repeat (8 * `CHASE_TICK_DIV) step(3'b000);
        if (led == '0) fail_run("player did not die on the brick");
        press(LEFT_BTN);
        press(UP_BTN);
        expect_count(5);
    endtask

    task automatic test_car_death();
        reset_dut();
        wait_lane(`START_COL, 4, 1, 1'b0); // car in col 3 when the player lands
        press(UP_BTN);
        repeat (4) step(3'b000);
        if (led == '0) fail_run("player was not hit by the car");
        expect_count(1);
    endtask

    task automatic test_win();
        digit_en_t seen;
        reset_dut();
        press(RIGHT_BTN);
        wait_lane(`START_COL + 1, 1, 12, 1'b1);
        repeat (5) press(UP_BTN);
        seen = '0;
        repeat (10 * `SCAN_TICK_DIV) begin
            step(3'b000);
            seen = seen | digit_enable;
        end
        if (seen != 4'b1111) fail_run("panel did not scan all four digits after the win");
        expect_count(6);
    endtask

    initial begin
        btn_up    = 1'b0;
        btn_left  = 1'b0;
        btn_right = 1'b0;
        reset_req = 1'b0;
        rst_prev  = 1'b0;
        btn_prev  = '0;
        model_reset();
        test_after_reset();
        test_moves_and_limits();
        test_rollover();
        test_brick_death();
        test_car_death();
        test_win();
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+hw
hw/game_pkg.sv
hw/display_pkg.sv
hw/board_if.sv
hw/tick_gen.sv
hw/player_ctrl.sv
hw/car_lane.sv
hw/game_rules.sv
hw/panel_driver.sv
hw/crossing_top.sv
test/tb_clock.sv
test/crossing_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the crossing testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module crossing_tb -f sources.f -o crossing_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/crossing_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF "** PASS **"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
